/* bench/tb_db_nwr_requester.sv */
// Directed testbench for the doorbell and NWRITE requester with a simple target model
`timescale 1ns/1ps
`default_nettype none

module tb_db_nwr_requester;

    import srio_req_pkg::*;

    localparam int          WAIT_LIMIT = 3000;
    localparam logic [15:0] SRC_ID     = 16'h0011;
    localparam logic [15:0] DES_ID     = 16'h00F0;

    // One captured ireq beat
    typedef struct packed {
        logic        last;
        logic [7:0]  keep;
        logic [63:0] data;
        logic [31:0] user;
    } ireq_beat_t;

    logic        log_clk = 1'b0;
    logic        log_rst;
    logic        self_check;
    logic        nwr_req;
    logic        link_up;
    logic        user_valid;
    user_entry_t user_entry;
    logic        user_tready;
    logic        nwr_ready;
    logic        nwr_busy;
    logic        nwr_done_ack;
    logic        rapidio_ready;
    logic        error;
    logic [1:0]  error_type;
    logic        ireq_tvalid;
    logic        ireq_tready = 1'b0;
    logic        ireq_tlast;
    logic [63:0] ireq_tdata;
    logic [7:0]  ireq_tkeep;
    logic [31:0] ireq_tuser;
    logic        iresp_tvalid;
    logic        iresp_tready;
    logic [63:0] iresp_tdata;
    logic [31:0] iresp_tuser;

    ireq_beat_t  beat_q[$];
    user_entry_t exp_q[$];
    logic [1:0]  err_q[$];
    int          ack_count = 0;
    int          errors = 0;
    int          tests_run = 0;
    logic        stall_en = 1'b0;

    db_nwr_requester DUT (
        .log_clk (log_clk), .log_rst (log_rst),
        .self_check_i (self_check), .nwr_req_i (nwr_req), .link_initialized_i (link_up),
        .src_id_i (SRC_ID), .des_id_i (DES_ID),
        .user_valid_i (user_valid), .user_entry_i (user_entry), .user_tready_o (user_tready),
        .nwr_ready_o (nwr_ready), .nwr_busy_o (nwr_busy), .nwr_done_ack_o (nwr_done_ack),
        .rapidio_ready_o (rapidio_ready), .error_o (error), .error_type_o (error_type),
        .ireq_tvalid_o (ireq_tvalid), .ireq_tready_i (ireq_tready), .ireq_tlast_o (ireq_tlast),
        .ireq_tdata_o (ireq_tdata), .ireq_tkeep_o (ireq_tkeep), .ireq_tuser_o (ireq_tuser),
        .iresp_tvalid_i (iresp_tvalid), .iresp_tready_o (iresp_tready),
        .iresp_tdata_i (iresp_tdata), .iresp_tuser_i (iresp_tuser)
    );

    always #50 log_clk = ~log_clk;

    // Random back-pressure on ireq
    always @(posedge log_clk) begin
        if (stall_en) begin
            ireq_tready <= ($urandom_range(3, 0) != 0);
        end else begin
            ireq_tready <= 1'b1;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge log_clk) begin
        if (ireq_tvalid && ireq_tready) begin
            beat_q.push_back({ireq_tlast, ireq_tkeep, ireq_tdata, ireq_tuser});
        end
        if (error) begin
            err_q.push_back(error_type);
        end
        if (nwr_done_ack) begin
            ack_count++;
        end
    end

    task automatic check_hdr(input string test, input srio_hdr_u exp, input srio_hdr_u act);
        if (act !== exp) begin
            $display("Mismatch in %s: header expected %h, actual %h", test, exp, act);
            errors++;
        end
    endtask

    task automatic check_beat(input string test, input logic [63:0] exp_data,
                              input logic [7:0] exp_keep, input ireq_beat_t act);
        if ((act.data !== exp_data) || (act.keep !== exp_keep)) begin
            $display("Mismatch in %s: beat expected %h/%h, actual %h/%h",
                     test, exp_data, exp_keep, act.data, act.keep);
            errors++;
        end
    endtask

    task automatic check_err(input string test, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s: error type expected %0d, actual %0d", test, exp, act);
            errors++;
        end
    endtask

    task automatic check_user(input string test, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s: tuser expected %h, actual %h", test, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string test, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("Mismatch in %s: %s expected %b, actual %b", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Tests run: %0d, errors: %0d", tests_run, errors + 1);
        $display("Verification failed");
        $finish;
    endtask

    task automatic finish_test(input string test, input int errs_before);
        tests_run++;
        $display("%s: done, %0d errors", test, errors - errs_before);
    endtask

    task automatic wait_beat(output ireq_beat_t beat, input string what);
        int cycles;
        cycles = 0;
        while (beat_q.size() == 0) begin
            if (cycles == WAIT_LIMIT) begin
                stop_on_timeout(what);
            end
            @(posedge log_clk);
            cycles++;
        end
        beat = beat_q.pop_front();
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge log_clk);
        while (nwr_busy) begin
            if (cycles == WAIT_LIMIT) begin
                stop_on_timeout("the requester to return to idle");
            end
            @(negedge log_clk);
            cycles++;
        end
    endtask

    task automatic wait_error(output logic [1:0] etype);
        int cycles;
        cycles = 0;
        while (err_q.size() == 0) begin
            if (cycles == WAIT_LIMIT) begin
                stop_on_timeout("an error pulse");
            end
            @(posedge log_clk);
            cycles++;
        end
        etype = err_q.pop_front();
    endtask

    task automatic wait_ack(input int target);
        int cycles;
        cycles = 0;
        while (ack_count < target) begin
            if (cycles == WAIT_LIMIT) begin
                stop_on_timeout("the transfer acknowledge");
            end
            @(posedge log_clk);
            cycles++;
        end
    endtask

    task automatic start_self_check();
        @(posedge log_clk);
        self_check <= 1'b1;
        @(posedge log_clk);
        self_check <= 1'b0;
    endtask

    task automatic start_nwr();
        @(posedge log_clk);
        nwr_req <= 1'b1;
        @(posedge log_clk);
        nwr_req <= 1'b0;
    endtask

    // Target model, one response beat
    task automatic send_response(input logic [15:0] src, input logic [15:0] info);
        srio_hdr_u hdr;
        hdr          = '0;
        hdr.db.ftype = FTYPE_DOORBELL;
        hdr.db.info  = info;
        @(posedge log_clk);
        iresp_tvalid <= 1'b1;
        iresp_tdata  <= hdr;
        iresp_tuser  <= {src, SRC_ID};
        @(posedge log_clk);
        iresp_tvalid <= 1'b0;
    endtask

    task automatic push_entry(input user_entry_t e);
        int cycles;
        cycles = 0;
        @(posedge log_clk);
        user_valid <= 1'b1;
        user_entry <= e;
        @(negedge log_clk);
        while (!user_tready) begin
            if (cycles == WAIT_LIMIT) begin
                stop_on_timeout("space in the user FIFO");
            end
            @(negedge log_clk);
            cycles++;
        end
        @(posedge log_clk);
        user_valid <= 1'b0;
    endtask

    // Size beat then random data beats, partial keep on a short last beat
    task automatic load_transfer(input int nbytes);
        user_entry_t e;
        int          nbeats;
        int          nb;
        nbeats  = (nbytes + 7) / 8;
        e       = '0;
        e.first = 1'b1;
        e.keep  = 8'hFF;
        e.data  = 64'(nbytes - 1);
        push_entry(e);
        for (int i = 0; i < nbeats; i++) begin
            nb     = (nbytes - 8 * i > 8) ? 8 : nbytes - 8 * i;
            e      = '0;
            e.last = (i == nbeats - 1);
            e.keep = 8'(8'hFF >> (8 - nb));
            e.data = {$urandom, $urandom};
            exp_q.push_back(e);
            push_entry(e);
        end
    endtask

    task automatic expect_doorbell(input string test, input logic [15:0] info);
        srio_hdr_u  exp_hdr;
        ireq_beat_t beat;
        exp_hdr          = '0;
        exp_hdr.db.ftype = FTYPE_DOORBELL;
        exp_hdr.db.prio  = REQ_PRIO;
        exp_hdr.db.info  = info;
        wait_beat(beat, "a doorbell beat");
        check_hdr(test, exp_hdr, beat.data);
        check_flag(test, "doorbell tlast", 1'b1, beat.last);
        check_user(test, {SRC_ID, DES_ID}, beat.user);
    endtask

    // Whole NWRITE plus the integrity doorbell that follows it
    task automatic send_transfer(input string test, input logic ep, input int nbytes);
        srio_hdr_u   exp_hdr;
        ireq_beat_t  beat;
        user_entry_t e;
        load_transfer(nbytes);
        start_nwr();
        @(negedge log_clk);
        check_flag(test, "rapidio_ready in NWR", 1'b0, rapidio_ready);
        exp_hdr           = '0;
        exp_hdr.nwr.tid   = {7'd0, ep};
        exp_hdr.nwr.ftype = FTYPE_NWRITE;
        exp_hdr.nwr.ttype = TTYPE_NWRITE;
        exp_hdr.nwr.prio  = REQ_PRIO;
        exp_hdr.nwr.size  = 8'(nbytes - 1);
        exp_hdr.nwr.addr  = ep ? EP1_ADDR : 34'd0;
        wait_beat(beat, "the NWRITE header");
        check_hdr(test, exp_hdr, beat.data);
        check_flag(test, "header tlast", 1'b0, beat.last);
        check_user(test, {SRC_ID, DES_ID}, beat.user);
        while (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            wait_beat(beat, "an NWRITE data beat");
            check_beat(test, e.data, e.keep, beat);
            check_flag(test, "data tlast", e.last, beat.last);
        end
        expect_doorbell(test, ep ? 16'h0200 : 16'h0201);
    endtask

    task automatic test_self_check_ready();
        int errs_before;
        errs_before = errors;
        check_flag("self_check_ready", "iresp_tready", 1'b1, iresp_tready);
        start_self_check();
        @(negedge log_clk);
        check_flag("self_check_ready", "rapidio_ready in DB_REQ", 1'b0, rapidio_ready);
        expect_doorbell("self_check_ready", DB_INFO_SELF_CHECK);
        send_response(RESP_SRC_ID, DB_INFO_READY);
        wait_idle();
        check_flag("self_check_ready", "nwr_ready", 1'b1, nwr_ready);
        check_flag("self_check_ready", "rapidio_ready in idle", 1'b1, rapidio_ready);
        finish_test("self_check_ready", errs_before);
    endtask

    task automatic test_busy_then_timeout();
        int         errs_before;
        int         acks_before;
        logic [1:0] etype;
        errs_before = errors;
        acks_before = ack_count;
        start_self_check();
        expect_doorbell("busy_timeout", DB_INFO_SELF_CHECK);
        send_response(RESP_SRC_ID, DB_INFO_BUSY);
        wait_idle();
        check_flag("busy_timeout", "nwr_ready after busy", 1'b0, nwr_ready);
        err_q.delete();
        // Second self-check gets no answer
        start_self_check();
        expect_doorbell("busy_timeout", DB_INFO_SELF_CHECK);
        wait_error(etype);
        check_err("busy_timeout", 2'd1, etype);
        wait_idle();
        check_flag("busy_timeout", "nwr_ready after timeout", 1'b0, nwr_ready);
        check_flag("busy_timeout", "stray acknowledge", 1'b0, ack_count != acks_before);
        check_flag("busy_timeout", "extra ireq beat", 1'b0, beat_q.size() != 0);
        finish_test("busy_timeout", errs_before);
    endtask

    task automatic test_nwrite_ep(input string test, input logic ep, input int nbytes);
        int errs_before;
        int acks_before;
        errs_before = errors;
        acks_before = ack_count;
        send_transfer(test, ep, nbytes);
        send_response(RESP_SRC_ID, ep ? 16'h0200 : 16'h0201);
        wait_ack(acks_before + 1);
        wait_idle();
        finish_test(test, errs_before);
    endtask

    task automatic test_integ_timeout();
        int         errs_before;
        int         acks_before;
        logic [1:0] etype;
        errs_before = errors;
        acks_before = ack_count;
        err_q.delete();
        send_transfer("integ_timeout", 1'b0, 16);
        wait_error(etype);
        check_err("integ_timeout", 2'd2, etype);
        wait_idle();
        // Endpoint must not have moved
        send_transfer("integ_timeout", 1'b0, 16);
        send_response(16'h00F1, 16'h0201);
        repeat (20) @(negedge log_clk);
        check_flag("integ_timeout", "ack from wrong source", 1'b0, ack_count != acks_before);
        check_flag("integ_timeout", "still waiting", 1'b1, nwr_busy);
        check_flag("integ_timeout", "rapidio_ready while waiting", 1'b1, rapidio_ready);
        send_response(RESP_SRC_ID, 16'h0201);
        wait_ack(acks_before + 1);
        wait_idle();
        // Ready from a foreign source during a self-check
        start_self_check();
        expect_doorbell("integ_timeout", DB_INFO_SELF_CHECK);
        send_response(16'h00F1, DB_INFO_READY);
        repeat (20) @(negedge log_clk);
        check_flag("integ_timeout", "nwr_ready from wrong source", 1'b0, nwr_ready);
        check_flag("integ_timeout", "self-check still waiting", 1'b1, nwr_busy);
        send_response(RESP_SRC_ID, DB_INFO_READY);
        wait_idle();
        check_flag("integ_timeout", "nwr_ready from valid source", 1'b1, nwr_ready);
        finish_test("integ_timeout", errs_before);
    endtask

    initial begin
        void'($urandom(32'h50df_bc79));
        log_rst      <= 1'b1;
        self_check   <= 1'b0;
        nwr_req      <= 1'b0;
        link_up      <= 1'b1;
        user_valid   <= 1'b0;
        user_entry   <= '0;
        iresp_tvalid <= 1'b0;
        iresp_tdata  <= '0;
        iresp_tuser  <= '0;
        repeat (2) @(posedge log_clk);
        log_rst <= 1'b0;
        test_self_check_ready();
        test_busy_then_timeout();
        stall_en = 1'b1;
        test_nwrite_ep("nwrite_stalls", 1'b0, 40);
        test_nwrite_ep("endpoint_toggle", 1'b1, 21);
        test_integ_timeout();
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
src/srio_req_pkg.sv
src/user_data_fifo.sv
src/resp_decoder.sv
src/req_sequencer.sv
src/db_nwr_requester.sv
bench/tb_db_nwr_requester.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module tb_db_nwr_requester -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1

/* src/db_nwr_requester.sv */
// Doorbell and NWRITE requester top, joins the user FIFO, response decoder and sequencer
`timescale 1ns/1ps
`default_nettype none

module db_nwr_requester (
    input  wire logic                      log_clk,
    input  wire logic                      log_rst,
    input  wire logic                      self_check_i,
    input  wire logic                      nwr_req_i,
    input  wire logic                      link_initialized_i,
    input  wire logic [15:0]               src_id_i,
    input  wire logic [15:0]               des_id_i,
    // User beat stream
    input  wire logic                      user_valid_i,
    input  wire srio_req_pkg::user_entry_t user_entry_i,
    output logic                           user_tready_o,
    // Status
    output logic                           nwr_ready_o,
    output logic                           nwr_busy_o,
    output logic                           nwr_done_ack_o,
    output logic                           rapidio_ready_o,
    output logic                           error_o,
    output logic [1:0]                     error_type_o,
    // ireq stream
    output logic                           ireq_tvalid_o,
    input  wire logic                      ireq_tready_i,
    output logic                           ireq_tlast_o,
    output logic [63:0]                    ireq_tdata_o,
    output logic [7:0]                     ireq_tkeep_o,
    output logic [31:0]                    ireq_tuser_o,
    // iresp stream
    input  wire logic                      iresp_tvalid_i,
    output logic                           iresp_tready_o,
    input  wire logic [63:0]               iresp_tdata_i,
    input  wire logic [31:0]               iresp_tuser_i
);

    import srio_req_pkg::*;

    user_entry_t head;
    logic        head_valid;
    logic        fifo_full;
    logic        pop;
    logic        resp_ready;
    logic        resp_busy;
    logic        resp_confirm;
    logic [15:0] expect_info;

    assign user_tready_o  = ~fifo_full;
    // Responses are always taken
    assign iresp_tready_o = 1'b1;

    user_data_fifo u_fifo (
        .log_clk      (log_clk),
        .log_rst      (log_rst),
        .wr_valid_i   (user_valid_i),
        .wr_entry_i   (user_entry_i),
        .pop_i        (pop),
        .full_o       (fifo_full),
        .head_o       (head),
        .head_valid_o (head_valid)
    );

    resp_decoder u_decoder (
        .log_clk        (log_clk),
        .log_rst        (log_rst),
        .iresp_tvalid_i (iresp_tvalid_i),
        .iresp_tdata_i  (iresp_tdata_i),
        .iresp_tuser_i  (iresp_tuser_i),
        .expect_info_i  (expect_info),
        .ready_o        (resp_ready),
        .busy_o         (resp_busy),
        .confirm_o      (resp_confirm)
    );

    req_sequencer u_sequencer (
        .log_clk            (log_clk),
        .log_rst            (log_rst),
        .self_check_i       (self_check_i),
        .nwr_req_i          (nwr_req_i),
        .link_initialized_i (link_initialized_i),
        .src_id_i           (src_id_i),
        .des_id_i           (des_id_i),
        .head_i             (head),
        .head_valid_i       (head_valid),
        .ready_i            (resp_ready),
        .busy_i             (resp_busy),
        .confirm_i          (resp_confirm),
        .ireq_tready_i      (ireq_tready_i),
        .pop_o              (pop),
        .expect_info_o      (expect_info),
        .ireq_tvalid_o      (ireq_tvalid_o),
        .ireq_tlast_o       (ireq_tlast_o),
        .ireq_tdata_o       (ireq_tdata_o),
        .ireq_tkeep_o       (ireq_tkeep_o),
        .ireq_tuser_o       (ireq_tuser_o),
        .nwr_ready_o        (nwr_ready_o),
        .nwr_busy_o         (nwr_busy_o),
        .nwr_done_ack_o     (nwr_done_ack_o),
        .rapidio_ready_o    (rapidio_ready_o),
        .error_o            (error_o),
        .error_type_o       (error_type_o)
    );

endmodule

`default_nettype wire

/* src/req_sequencer.sv */
// Request sequencer, runs the doorbell and NWRITE transaction flow and builds ireq beats
`timescale 1ns/1ps
`default_nettype none

module req_sequencer (
    input  wire logic                      log_clk,
    input  wire logic                      log_rst,
    input  wire logic                      self_check_i,
    input  wire logic                      nwr_req_i,
    input  wire logic                      link_initialized_i,
    input  wire logic [15:0]               src_id_i,
    input  wire logic [15:0]               des_id_i,
    input  wire srio_req_pkg::user_entry_t head_i,
    input  wire logic                      head_valid_i,
    input  wire logic                      ready_i,
    input  wire logic                      busy_i,
    input  wire logic                      confirm_i,
    input  wire logic                      ireq_tready_i,
    output logic                           pop_o,
    output logic [15:0]                    expect_info_o,
    output logic                           ireq_tvalid_o,
    output logic                           ireq_tlast_o,
    output logic [63:0]                    ireq_tdata_o,
    output logic [7:0]                     ireq_tkeep_o,
    output logic [31:0]                    ireq_tuser_o,
    output logic                           nwr_ready_o,
    output logic                           nwr_busy_o,
    output logic                           nwr_done_ack_o,
    output logic                           rapidio_ready_o,
    output logic                           error_o,
    output logic [1:0]                     error_type_o
);

    import srio_req_pkg::*;

    req_state_t  state;
    timer_t      timer;
    logic        timeout;
    logic        ep_sel;
    logic        accept;
    logic        db_load;
    logic        beat_load;
    srio_hdr_u   db_hdr;
    srio_hdr_u   nwr_hdr;
    logic [63:0] next_data;
    logic [7:0]  next_keep;
    logic        next_last;

    assign accept = ireq_tvalid_o && ireq_tready_i;

    // Refill from the FIFO when the output slot frees up, but never past tlast
    assign pop_o = (state == NWR) && head_valid_i
                && (!ireq_tvalid_o || (ireq_tready_i && !ireq_tlast_o));

    // Doorbells are single beats loaded into an empty slot
    assign db_load   = ((state == DB_REQ) || (state == INTEG_REQ)) && !ireq_tvalid_o;
    assign beat_load = pop_o || db_load;

    assign expect_info_o = ep_sel ? DB_INFO_INTEG_BASE : DB_INFO_INTEG_BASE + 16'd1;

    assign nwr_busy_o      = (state != IDLE);
    assign rapidio_ready_o = !((state == DB_REQ) || (state == NWR));

    assign timeout = (timer == timer_t'(TIMEOUT_CYCLES - 1));

    always_comb begin
        db_hdr          = '0;
        db_hdr.db.ftype = FTYPE_DOORBELL;
        db_hdr.db.prio  = REQ_PRIO;
        db_hdr.db.info  = (state == DB_REQ) ? DB_INFO_SELF_CHECK : expect_info_o;

        // Endpoint select doubles as the transaction ID
        nwr_hdr           = '0;
        nwr_hdr.nwr.tid   = {7'd0, ep_sel};
        nwr_hdr.nwr.ftype = FTYPE_NWRITE;
        nwr_hdr.nwr.ttype = TTYPE_NWRITE;
        nwr_hdr.nwr.prio  = REQ_PRIO;
        nwr_hdr.nwr.size  = head_i.data[7:0];
        nwr_hdr.nwr.addr  = ep_sel ? EP1_ADDR : '0;

        if (db_load) begin
            next_data = db_hdr;
            next_keep = 8'hFF;
            next_last = 1'b1;
        end else if (head_i.first) begin
            next_data = nwr_hdr;
            next_keep = 8'hFF;
            next_last = 1'b0;
        end else begin
            next_data = head_i.data;
            next_keep = head_i.keep;
            next_last = head_i.last;
        end
    end

    // Beat payload
    always_ff @(posedge log_clk) begin
        if (beat_load) begin
            ireq_tdata_o <= next_data;
            ireq_tkeep_o <= next_keep;
            ireq_tuser_o <= {src_id_i, des_id_i};
        end
    end

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            ireq_tvalid_o <= 1'b0;
            ireq_tlast_o  <= 1'b0;
        end else if (beat_load) begin
            ireq_tvalid_o <= 1'b1;
            ireq_tlast_o  <= next_last;
        end else if (accept) begin
            ireq_tvalid_o <= 1'b0;
            ireq_tlast_o  <= 1'b0;
        end
    end

    // Response timer runs only while a reply is awaited
    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            timer <= '0;
        end else if ((state == DB_RESP) || (state == WAIT_ACK)) begin
            timer <= timer + 1'b1;
        end else begin
            timer <= '0;
        end
    end

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            state          <= IDLE;
            ep_sel         <= 1'b0;
            nwr_ready_o    <= 1'b0;
            nwr_done_ack_o <= 1'b0;
            error_o        <= 1'b0;
            error_type_o   <= 2'd0;
        end else begin
            nwr_done_ack_o <= 1'b0;
            error_o        <= 1'b0;
            error_type_o   <= 2'd0;
            case (state)
                IDLE: begin
                    if (link_initialized_i && self_check_i) begin
                        nwr_ready_o <= 1'b0;
                        state       <= DB_REQ;
                    end else if (link_initialized_i && nwr_req_i) begin
                        state <= NWR;
                    end
                end
                DB_REQ: begin
                    if (accept) begin
                        state <= DB_RESP;
                    end
                end
                DB_RESP: begin
                    if (ready_i) begin
                        nwr_ready_o <= 1'b1;
                        state       <= IDLE;
                    end else if (busy_i) begin
                        nwr_ready_o <= 1'b0;
                        state       <= IDLE;
                    end else if (timeout) begin
                        error_o      <= 1'b1;
                        error_type_o <= 2'd1;
                        state        <= IDLE;
                    end
                end
                NWR: begin
                    if (accept && ireq_tlast_o) begin
                        state <= INTEG_REQ;
                    end
                end
                INTEG_REQ: begin
                    if (accept) begin
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (confirm_i) begin
                        // Next transfer goes to the other endpoint
                        nwr_done_ack_o <= 1'b1;
                        ep_sel         <= ~ep_sel;
                        state          <= IDLE;
                    end else if (timeout) begin
                        error_o      <= 1'b1;
                        error_type_o <= 2'd2;
                        state        <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/resp_decoder.sv */
// Response decoder, turns inbound doorbell responses into ready, busy and confirm strobes
`timescale 1ns/1ps
`default_nettype none

module resp_decoder (
    input  wire logic        log_clk,
    input  wire logic        log_rst,
    input  wire logic        iresp_tvalid_i,
    input  wire logic [63:0] iresp_tdata_i,
    input  wire logic [31:0] iresp_tuser_i,
    input  wire logic [15:0] expect_info_i,
    output logic             ready_o,
    output logic             busy_o,
    output logic             confirm_o
);

    import srio_req_pkg::*;

    srio_hdr_u resp_hdr;
    logic      resp_hit;

    assign resp_hdr = iresp_tdata_i;

    // Only doorbells from the expected source count
    assign resp_hit = iresp_tvalid_i
                   && (resp_hdr.db.ftype == FTYPE_DOORBELL)
                   && (iresp_tuser_i[31:16] == RESP_SRC_ID);

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            ready_o   <= 1'b0;
            busy_o    <= 1'b0;
            confirm_o <= 1'b0;
        end else begin
            ready_o   <= resp_hit && (resp_hdr.db.info == DB_INFO_READY);
            busy_o    <= resp_hit && (resp_hdr.db.info == DB_INFO_BUSY);
            confirm_o <= resp_hit && (resp_hdr.db.info == expect_info_i);
        end
    end

endmodule

`default_nettype wire

/* src/srio_req_pkg.sv */
// SRIO requester package holding packet field constants, beat layouts and FSM states
`default_nettype none

package srio_req_pkg;

    // Format and transaction types of the logical layer
    localparam logic [3:0] FTYPE_DOORBELL = 4'hA;
    localparam logic [3:0] FTYPE_NWRITE   = 4'h5;
    localparam logic [3:0] TTYPE_NWRITE   = 4'h4;
    localparam logic [1:0] REQ_PRIO       = 2'h1;

    // Responses are only accepted from this source
    localparam logic [15:0] RESP_SRC_ID = 16'h00F0;

    // Doorbell info codes
    localparam logic [15:0] DB_INFO_SELF_CHECK = 16'h0101;
    localparam logic [15:0] DB_INFO_READY      = 16'h0100;
    localparam logic [15:0] DB_INFO_BUSY       = 16'h01FF;
    // Integrity doorbell is base + 1 for endpoint 0, base for endpoint 1
    localparam logic [15:0] DB_INFO_INTEG_BASE = 16'h0200;

    // Second endpoint sits 1 MB above the first
    localparam logic [33:0] EP1_ADDR = 34'h1 << 20;

    // Response wait limit in log_clk cycles
    localparam int TIMEOUT_CYCLES = 1024;

    // User data FIFO geometry
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    typedef logic [$clog2(TIMEOUT_CYCLES)-1:0] timer_t;

    // Doorbell layout of the first beat
    typedef struct packed {
        logic [7:0]  tid;
        logic [3:0]  ftype;
        logic [3:0]  rsvd0;
        logic        rsvd1;
        logic [1:0]  prio;
        logic        crf;
        logic [11:0] rsvd2;
        logic [15:0] info;
        logic [15:0] rsvd3;
    } db_hdr_t;

    // NWRITE layout of the first beat
    typedef struct packed {
        logic [7:0]  tid;
        logic [3:0]  ftype;
        logic [3:0]  ttype;
        logic        rsvd0;
        logic [1:0]  prio;
        logic        crf;
        logic [7:0]  size;
        logic [1:0]  rsvd1;
        logic [33:0] addr;
    } nwr_hdr_t;

    typedef union packed {
        db_hdr_t  db;
        nwr_hdr_t nwr;
    } srio_hdr_u;

    // One user beat; a first beat holds byte count minus one in data[7:0]
    typedef struct packed {
        logic        first;
        logic        last;
        logic [7:0]  keep;
        logic [63:0] data;
    } user_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        DB_REQ,
        DB_RESP,
        NWR,
        INTEG_REQ,
        WAIT_ACK
    } req_state_t;

endpackage

`default_nettype wire

/* src/user_data_fifo.sv */
// User data FIFO, show-ahead, holding the size beat and data beats of each transfer
`timescale 1ns/1ps
`default_nettype none

module user_data_fifo (
    input  wire logic                        log_clk,
    input  wire logic                        log_rst,
    input  wire logic                        wr_valid_i,
    input  wire srio_req_pkg::user_entry_t   wr_entry_i,
    input  wire logic                        pop_i,
    output logic                             full_o,
    output srio_req_pkg::user_entry_t        head_o,
    output logic                             head_valid_o
);

    import srio_req_pkg::*;

    user_entry_t        mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    assign full_o       = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign head_valid_o = (count != '0);

    // Writes while full are dropped
    assign do_wr = wr_valid_i && !full_o;
    assign do_rd = pop_i && head_valid_o;

    // Head entry is visible without a read cycle
    assign head_o = mem[rd_ptr];

    always_ff @(posedge log_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_entry_i;
        end
    end

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire
